//--- source/vector_settings.svh
`ifndef VECTOR_SETTINGS_SVH
`define VECTOR_SETTINGS_SVH

// Width of one vector register in bits
// Any multiple of 32 up to 256
`define VECTOR_VLEN 64

// Bytes per vector register
`define VECTOR_VLENB (`VECTOR_VLEN / 8)

`endif

//--- source/vector_pkg.sv
`include "vector_settings.svh"

package vector_pkg;

    // Coarse class from the core's decoder
    typedef enum logic [2:0] {
        NONE     = 3'd0,
        VECTOR   = 3'd1,
        VSETVL   = 3'd2,
        VSETVLI  = 3'd3,
        VSETIVLI = 3'd4
    } instr_class_e;

    typedef enum logic [3:0] {
        VADD    = 4'd0,
        VSUB    = 4'd1,
        VAND    = 4'd2,
        VOR     = 4'd3,
        VXOR    = 4'd4,
        VMINU   = 4'd5,
        VMAXU   = 4'd6,
        VSLL    = 4'd7,
        VSRL    = 4'd8,
        VMV_X_S = 4'd9
    } vector_op_e;

    // funct3 operand categories, RVV encodings
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } op_cat_e;

    typedef enum logic [2:0] {
        EW8  = 3'd0,
        EW16 = 3'd1,
        EW32 = 3'd2
    } vsew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'd0,
        LMUL_2 = 3'd1,
        LMUL_4 = 3'd2,
        LMUL_8 = 3'd3
    } vlmul_e;

    typedef enum logic [1:0] {
        V_IDLE = 2'd0,
        V_EXEC = 2'd1,
        V_END  = 2'd2
    } vector_state_e;

    typedef struct packed {
        logic [25:0] zero;
        vsew_e       vsew;
        vlmul_e      vlmul;
    } vtype_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        op_cat_e    funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } arith_fmt_t;

    // Bit 30 is part of zimm for vsetvli, only the low vtype bits matter here
    typedef struct packed {
        logic [1:0] fmt;
        logic [9:0] zimm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } config_fmt_t;

    typedef union packed {
        arith_fmt_t  arith_fmt;
        config_fmt_t config_fmt;
    } vector_instr_u;

    typedef struct packed {
        logic [`VECTOR_VLEN-1:0] first_operand;
        logic [`VECTOR_VLEN-1:0] second_operand;
    } alu_operands_t;

endpackage

//--- source/vector_csrs.sv
`timescale 1ns/100ps
`include "vector_settings.svh"

module vector_csrs (
    input  logic                      clk,
    input  logic                      reset_n,

    input  logic                      config_write_i,
    input  vector_pkg::instr_class_e  instruction_class_i,
    input  vector_pkg::vector_instr_u instruction_i,
    input  logic [31:0]               op1_scalar_i,
    input  logic [31:0]               op2_scalar_i,

    output vector_pkg::vtype_t        vtype_o,
    output vector_pkg::vsew_e         vsew_o,
    output vector_pkg::vlmul_e        vlmul_o,
    output logic [31:0]               vl_o,
    output logic [31:0]               vl_next_o
);

    logic [31:0]        vtype_source;
    vector_pkg::vtype_t vtype_next;
    logic [31:0]        vlmax;
    logic [31:0]        avl;

    // vsetvl reads vtype from rs2, the immediate forms from zimm
    assign vtype_source = (instruction_class_i == vector_pkg::VSETVL)
                        ? op2_scalar_i
                        : 32'(instruction_i.config_fmt.zimm);

    always_comb begin
        vtype_next       = '0;
        vtype_next.vsew  = vector_pkg::vsew_e'(vtype_source[5:3]);
        vtype_next.vlmul = vector_pkg::vlmul_e'(vtype_source[2:0]);
    end

    // (VLEN / SEW) * LMUL
    assign vlmax = (32'(`VECTOR_VLEN) >> (32'(vtype_next.vsew) + 32'd3)) << vtype_next.vlmul;

    always_comb begin
        if (instruction_class_i == vector_pkg::VSETIVLI)
            avl = 32'(instruction_i.config_fmt.rs1);
        else if (instruction_i.config_fmt.rs1 == 5'd0)
            avl = vlmax;
        else
            avl = op1_scalar_i;
    end

    assign vl_next_o = (avl < vlmax) ? avl : vlmax;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vtype_o <= '0;
            vl_o    <= '0;
        end
        else if (config_write_i) begin
            vtype_o <= vtype_next;
            vl_o    <= vl_next_o;
        end
    end

    assign vsew_o  = vtype_o.vsew;
    assign vlmul_o = vtype_o.vlmul;

endmodule

//--- source/vector_regbank.sv
`timescale 1ns/100ps
`include "vector_settings.svh"

module vector_regbank (
    input  logic                      clk,
    input  logic                      reset_n,

    input  logic [4:0]                vs1_addr_i,
    input  logic [4:0]                vs2_addr_i,
    input  logic [4:0]                vd_addr_i,
    input  logic [4:0]                element_index_i,
    input  vector_pkg::vsew_e         vsew_i,
    input  logic [`VECTOR_VLENB-1:0]  byte_enable_i,
    input  logic [`VECTOR_VLEN-1:0]   write_data_i,

    output logic [`VECTOR_VLEN-1:0]   vs1_data_o,
    output logic [`VECTOR_VLEN-1:0]   vs2_data_o,
    output logic [31:0]               element_o
);

    logic [`VECTOR_VLEN-1:0] vregs [32];
    logic [`VECTOR_VLEN-1:0] element_shifted;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < 32; r++)
                vregs[r] <= '0;
        end
        else begin
            for (int b = 0; b < `VECTOR_VLENB; b++) begin
                if (byte_enable_i[b])
                    vregs[vd_addr_i][b*8 +: 8] <= write_data_i[b*8 +: 8];
            end
        end
    end

    assign vs1_data_o = vregs[vs1_addr_i];
    assign vs2_data_o = vregs[vs2_addr_i];

    // Element j sits at bit j * SEW
    assign element_shifted = vs2_data_o >> (32'(element_index_i) << (32'(vsew_i) + 32'd3));

    always_comb begin
        unique case (vsew_i)
            vector_pkg::EW8:  element_o = {{24{element_shifted[7]}}, element_shifted[7:0]};
            vector_pkg::EW16: element_o = {{16{element_shifted[15]}}, element_shifted[15:0]};
            default:          element_o = element_shifted[31:0];
        endcase
    end

endmodule

//--- source/vector_alu.sv
`timescale 1ns/100ps
`include "vector_settings.svh"

module vector_alu (
    input  vector_pkg::alu_operands_t operands_i,
    input  vector_pkg::vector_op_e    vector_operation_i,
    input  vector_pkg::vsew_e         vsew_i,
    output logic [`VECTOR_VLEN-1:0]   result_o
);

    localparam int VLENB = `VECTOR_VLENB;

    // One lane, operands zero-extended from the lane width
    function automatic logic [31:0] lane_op(
        input logic [31:0]            a,
        input logic [31:0]            b,
        input vector_pkg::vector_op_e op,
        input int unsigned            width
    );
        logic [31:0] mask;
        logic [4:0]  shamt;
        logic [31:0] value;
        mask  = 32'hFFFF_FFFF >> (32 - width);
        // Shift amount limited to log2(SEW) bits
        shamt = 5'(b & (width - 1));
        case (op)
            vector_pkg::VADD:  value = a + b;
            vector_pkg::VSUB:  value = a - b;
            vector_pkg::VAND:  value = a & b;
            vector_pkg::VOR:   value = a | b;
            vector_pkg::VXOR:  value = a ^ b;
            vector_pkg::VMINU: value = (a < b) ? a : b;
            vector_pkg::VMAXU: value = (a > b) ? a : b;
            vector_pkg::VSLL:  value = a << shamt;
            vector_pkg::VSRL:  value = a >> shamt;
            default:           value = a;
        endcase
        return value & mask;
    endfunction

    always_comb begin
        logic [31:0] lane;
        result_o = '0;
        unique case (vsew_i)
            vector_pkg::EW8: begin
                for (int i = 0; i < VLENB; i++) begin
                    lane = lane_op(32'(operands_i.first_operand[i*8 +: 8]),
                                   32'(operands_i.second_operand[i*8 +: 8]),
                                   vector_operation_i, 8);
                    result_o[i*8 +: 8] = lane[7:0];
                end
            end
            vector_pkg::EW16: begin
                for (int i = 0; i < VLENB/2; i++) begin
                    lane = lane_op(32'(operands_i.first_operand[i*16 +: 16]),
                                   32'(operands_i.second_operand[i*16 +: 16]),
                                   vector_operation_i, 16);
                    result_o[i*16 +: 16] = lane[15:0];
                end
            end
            default: begin
                for (int i = 0; i < VLENB/4; i++) begin
                    lane = lane_op(operands_i.first_operand[i*32 +: 32],
                                   operands_i.second_operand[i*32 +: 32],
                                   vector_operation_i, 32);
                    result_o[i*32 +: 32] = lane;
                end
            end
        endcase
    end

endmodule

//--- source/vector_unit.sv
`timescale 1ns/100ps
`include "vector_settings.svh"

module vector_unit (
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic [31:0]              instruction_i,
    input  vector_pkg::instr_class_e instruction_class_i,
    input  vector_pkg::vector_op_e   vector_operation_i,

    input  logic [31:0]              op1_scalar_i,
    input  logic [31:0]              op2_scalar_i,

    output logic                     hold_o,
    output vector_pkg::vtype_t       vtype_o,
    output logic [31:0]              res_scalar_o,
    output logic                     wr_en_scalar_o
);

    localparam int VLEN  = `VECTOR_VLEN;
    localparam int VLENB = `VECTOR_VLENB;

    vector_pkg::vector_instr_u  instr;
    logic                       config_write;
    logic                       start;
    logic                       shift_op;

    vector_pkg::vsew_e          vsew;
    vector_pkg::vlmul_e         vlmul;
    logic [31:0]                vl, vl_next;

    vector_pkg::vector_state_e  state, next_state;
    logic [3:0]                 member_count, member_r, group_size;

    logic [4:0]                 vs1_addr, vs2_addr, vd_addr_r;
    logic [VLEN-1:0]            vs1_data, vs2_data;
    logic [4:0]                 element_index;
    logic [31:0]                element;

    logic [VLEN-1:0]            scalar_replicated, imm_replicated;
    vector_pkg::alu_operands_t  operands, operands_r;
    logic [VLEN-1:0]            result;

    logic [31:0]                elements_per_reg, first_element;
    logic [VLENB-1:0]           byte_enable;

    ////////////////////
    // Decode
    ////////////////////

    assign instr        = instruction_i;
    assign config_write = instruction_class_i inside
                          {vector_pkg::VSETVL, vector_pkg::VSETVLI, vector_pkg::VSETIVLI};
    // vmv.x.s reads back in one cycle and never enters the group FSM
    assign start        = (instruction_class_i == vector_pkg::VECTOR)
                       && (vector_operation_i != vector_pkg::VMV_X_S);
    assign shift_op     = vector_operation_i inside {vector_pkg::VSLL, vector_pkg::VSRL};

    vector_csrs csrs (
        .clk                 (clk),
        .reset_n             (reset_n),
        .config_write_i      (config_write),
        .instruction_class_i (instruction_class_i),
        .instruction_i       (instr),
        .op1_scalar_i        (op1_scalar_i),
        .op2_scalar_i        (op2_scalar_i),
        .vtype_o             (vtype_o),
        .vsew_o              (vsew),
        .vlmul_o             (vlmul),
        .vl_o                (vl),
        .vl_next_o           (vl_next)
    );

    ////////////////////
    // Group FSM
    ////////////////////

    assign group_size = 4'd1 << vlmul;

    always_comb begin
        unique case (state)
            vector_pkg::V_IDLE:
                next_state = start ? vector_pkg::V_EXEC : vector_pkg::V_IDLE;
            vector_pkg::V_EXEC:
                // Last EXEC cycle writes member L-1
                next_state = (member_count == group_size) ? vector_pkg::V_END
                                                          : vector_pkg::V_EXEC;
            default:
                next_state = vector_pkg::V_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= vector_pkg::V_IDLE;
            member_count <= '0;
        end
        else begin
            state <= next_state;
            if (next_state == vector_pkg::V_EXEC)
                member_count <= member_count + 4'd1;
            else
                member_count <= '0;
        end
    end

    assign hold_o = (state == vector_pkg::V_EXEC) || (state == vector_pkg::V_IDLE && start);

    ////////////////////
    // Register file
    ////////////////////

    assign vs1_addr = instr.arith_fmt.vs1 + 5'(member_count);
    assign vs2_addr = instr.arith_fmt.vs2 + 5'(member_count);

    // Element index wraps at the element count of one register
    always_comb begin
        unique case (vsew)
            vector_pkg::EW8:  element_index = 5'(op1_scalar_i % 32'(VLENB));
            vector_pkg::EW16: element_index = 5'(op1_scalar_i % 32'(VLENB/2));
            default:          element_index = 5'(op1_scalar_i % 32'(VLENB/4));
        endcase
    end

    vector_regbank regbank (
        .clk             (clk),
        .reset_n         (reset_n),
        .vs1_addr_i      (vs1_addr),
        .vs2_addr_i      (vs2_addr),
        .vd_addr_i       (vd_addr_r),
        .element_index_i (element_index),
        .vsew_i          (vsew),
        .byte_enable_i   (byte_enable),
        .write_data_i    (result),
        .vs1_data_o      (vs1_data),
        .vs2_data_o      (vs2_data),
        .element_o       (element)
    );

    ////////////////////
    // Operands
    ////////////////////

    always_comb begin
        unique case (vsew)
            vector_pkg::EW8:  scalar_replicated = {(VLENB){op1_scalar_i[7:0]}};
            vector_pkg::EW16: scalar_replicated = {(VLENB/2){op1_scalar_i[15:0]}};
            default:          scalar_replicated = {(VLENB/4){op1_scalar_i}};
        endcase
    end

    // Shift amounts are unsigned, other immediates signed
    always_comb begin
        logic [31:0] imm;
        if (shift_op)
            imm = {27'd0, instr.arith_fmt.vs1};
        else
            imm = {{27{instr.arith_fmt.vs1[4]}}, instr.arith_fmt.vs1};
        unique case (vsew)
            vector_pkg::EW8:  imm_replicated = {(VLENB){imm[7:0]}};
            vector_pkg::EW16: imm_replicated = {(VLENB/2){imm[15:0]}};
            default:          imm_replicated = {(VLENB/4){imm}};
        endcase
    end

    always_comb begin
        operands.first_operand = vs2_data;
        unique case (instr.arith_fmt.funct3)
            vector_pkg::OPIVX: operands.second_operand = scalar_replicated;
            vector_pkg::OPIVI: operands.second_operand = imm_replicated;
            default:           operands.second_operand = vs1_data;
        endcase
    end

    // Member read this cycle, written next cycle
    always_ff @(posedge clk) begin
        operands_r <= operands;
        member_r   <= member_count;
        vd_addr_r  <= instr.arith_fmt.vd + 5'(member_count);
    end

    vector_alu alu (
        .operands_i         (operands_r),
        .vector_operation_i (vector_operation_i),
        .vsew_i             (vsew),
        .result_o           (result)
    );

    ////////////////////
    // Write enables
    ////////////////////

    assign elements_per_reg = 32'(VLENB) >> vsew;
    assign first_element    = 32'(member_r) * elements_per_reg;

    // Bytes of elements at or past vl stay untouched
    always_comb begin
        byte_enable = '0;
        if (state == vector_pkg::V_EXEC) begin
            for (int b = 0; b < VLENB; b++)
                byte_enable[b] = (first_element + (32'(b) >> vsew)) < vl;
        end
    end

    ////////////////////
    // Scalar result
    ////////////////////

    always_comb begin
        res_scalar_o   = '0;
        wr_en_scalar_o = 1'b0;
        if (config_write) begin
            res_scalar_o   = vl_next;
            wr_en_scalar_o = 1'b1;
        end
        else if (instruction_class_i == vector_pkg::VECTOR
              && vector_operation_i == vector_pkg::VMV_X_S) begin
            res_scalar_o   = element;
            wr_en_scalar_o = 1'b1;
        end
    end

endmodule

//--- tests/vector_unit_properties.sv
`timescale 1ns/100ps
`include "vector_settings.svh"

module vector_unit_properties (
    input logic                      clk,
    input logic                      reset_n,
    input logic                      hold_i,
    input vector_pkg::instr_class_e  instruction_class_i,
    input logic [`VECTOR_VLENB-1:0]  byte_enable_i
);

    int         assert_failures = 0;
    logic [4:0] hold_run;

    // Consecutive hold cycles before the current one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            hold_run <= '0;
        else if (hold_i)
            hold_run <= (hold_run == 5'h1F) ? hold_run : hold_run + 5'd1;
        else
            hold_run <= '0;
    end

    hold_limit: assert property (@(posedge clk) disable iff (!reset_n)
        hold_i |-> hold_run < 5'd9)
        else begin
            $error("hold_o stayed high for more than 9 cycles");
            assert_failures++;
        end

    config_no_hold: assert property (@(posedge clk) disable iff (!reset_n)
        instruction_class_i inside {vector_pkg::VSETVL, vector_pkg::VSETVLI,
                                    vector_pkg::VSETIVLI} |-> !hold_i)
        else begin
            $error("hold_o raised for a vsetvl-family instruction");
            assert_failures++;
        end

    // EXEC cycles are the hold cycles after the first one
    enables_outside_exec: assert property (@(posedge clk) disable iff (!reset_n)
        (!hold_i || $rose(hold_i)) |-> byte_enable_i == '0)
        else begin
            $error("byte enables active outside V_EXEC");
            assert_failures++;
        end

    hold_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !hold_i)
        else begin
            $error("hold_o high in the first cycle after reset");
            assert_failures++;
        end

endmodule

bind vector_unit vector_unit_properties property_checks (
    .clk                 (clk),
    .reset_n             (reset_n),
    .hold_i              (hold_o),
    .instruction_class_i (instruction_class_i),
    .byte_enable_i       (byte_enable)
);

//--- tests/vector_unit_tb.sv
`timescale 1ns/100ps
`include "vector_settings.svh"

module vector_unit_tb;

    localparam int VLEN        = `VECTOR_VLEN;
    localparam int CONFIG_RUNS = 40;
    localparam int OP_RUNS     = 30;
    localparam int TAIL_RUNS   = 8;
    localparam int SHIFT_RUNS  = 16;
    // Config, the operation and a full read-back of an LMUL 8 group at SEW 8
    localparam int OP_INSTRS   = 2 + VLEN;
    localparam int INSTR_COUNT = 4 + CONFIG_RUNS + (OP_RUNS + TAIL_RUNS + SHIFT_RUNS) * OP_INSTRS;
    localparam real TIMEOUT_NS = 2.0 * INSTR_COUNT * 10 * 100.0;

    logic                     clk;
    logic                     reset_n;
    logic [31:0]              instruction;
    vector_pkg::instr_class_e instruction_class;
    vector_pkg::vector_op_e   vector_operation;
    logic [31:0]              op1_scalar;
    logic [31:0]              op2_scalar;
    logic                     hold;
    vector_pkg::vtype_t       vtype;
    logic [31:0]              res_scalar;
    logic                     wr_en_scalar;

    // Reference model state
    logic [VLEN-1:0] model_regs [32];
    logic [31:0]     model_vl;
    logic [2:0]      model_sew;
    logic [2:0]      model_lmul;

    logic [15:0]     lfsr;
    int              errors;
    int              checks;
    int              tests_run;
    int              tests_failed;

    vector_unit UUT (
        .clk                 (clk),
        .reset_n             (reset_n),
        .instruction_i       (instruction),
        .instruction_class_i (instruction_class),
        .vector_operation_i  (vector_operation),
        .op1_scalar_i        (op1_scalar),
        .op2_scalar_i        (op2_scalar),
        .hold_o              (hold),
        .vtype_o             (vtype),
        .res_scalar_o        (res_scalar),
        .wr_en_scalar_o      (wr_en_scalar)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr     = {lfsr[14:0], feedback};
            value    = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] sew_mask();
        return 32'((33'd1 << (8 << model_sew)) - 33'd1);
    endfunction

    function automatic logic [31:0] model_element(input int r, input int idx);
        logic [VLEN-1:0] shifted;
        shifted = model_regs[r] >> (idx * (8 << model_sew));
        return shifted[31:0] & sew_mask();
    endfunction

    function automatic logic [31:0] sign_extend(input logic [31:0] value);
        return value[(8 << model_sew) - 1] ? (value | ~sew_mask()) : value;
    endfunction

    function automatic logic [31:0] model_op(input vector_pkg::vector_op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        int          width;
        width = 8 << model_sew;
        case (op)
            vector_pkg::VADD:  r = a + b;
            vector_pkg::VSUB:  r = a - b;
            vector_pkg::VAND:  r = a & b;
            vector_pkg::VOR:   r = a | b;
            vector_pkg::VXOR:  r = a ^ b;
            vector_pkg::VMINU: r = (a < b) ? a : b;
            vector_pkg::VMAXU: r = (a > b) ? a : b;
            vector_pkg::VSLL:  r = a << (b % width);
            vector_pkg::VSRL:  r = a >> (b % width);
            default:           r = a;
        endcase
        return r & sew_mask();
    endfunction

    task automatic write_model_element(input int r, input int idx, input logic [31:0] value);
        int width;
        width = 8 << model_sew;
        for (int b = 0; b < width; b++)
            model_regs[r][idx * width + b] = value[b];
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %08h, got %08h", name, expected, actual);
        end
    endtask

    // Drive on the rising edge, leave the caller at the following falling edge
    task automatic issue(input vector_pkg::instr_class_e cls, input vector_pkg::vector_op_e op,
                         input logic [31:0] word, input logic [31:0] op1,
                         input logic [31:0] op2);
        @(posedge clk);
        instruction_class <= cls;
        vector_operation  <= op;
        instruction       <= word;
        op1_scalar        <= op1;
        op2_scalar        <= op2;
        @(negedge clk);
    endtask

    task automatic configure(input vector_pkg::instr_class_e cls, input logic [2:0] sew,
                             input logic [2:0] lmul, input logic [4:0] rs1,
                             input logic [31:0] avl);
        logic [31:0] word;
        logic [31:0] vlmax;
        logic [31:0] requested;
        vlmax = (VLEN / (8 << sew)) << lmul;
        case (cls)
            vector_pkg::VSETIVLI: word = {2'b11, 4'd0, sew, lmul, rs1, 3'b111, 5'd1, 7'h57};
            vector_pkg::VSETVL:   word = {1'b1, 6'd0, 5'd2, rs1, 3'b111, 5'd1, 7'h57};
            default:              word = {1'b0, 5'd0, sew, lmul, rs1, 3'b111, 5'd1, 7'h57};
        endcase
        if (cls == vector_pkg::VSETIVLI)
            requested = 32'(rs1);
        else if (rs1 == 5'd0)
            requested = vlmax;
        else
            requested = avl;
        model_vl   = (requested < vlmax) ? requested : vlmax;
        model_sew  = sew;
        model_lmul = lmul;
        issue(cls, vector_pkg::VADD, word, avl, {26'd0, sew, lmul});
        check_value("hold_o", 32'd0, 32'(hold));
        check_value("wr_en_scalar_o", 32'd1, 32'(wr_en_scalar));
        check_value("res_scalar_o", model_vl, res_scalar);
        issue(vector_pkg::NONE, vector_pkg::VADD, 32'd0, 32'd0, 32'd0);
        check_value("vtype_o", {26'd0, model_sew, model_lmul}, 32'(vtype));
        check_value("wr_en_scalar_o", 32'd0, 32'(wr_en_scalar));
    endtask

    // vmv.x.s with an index that wraps at the element count
    task automatic read_back(input int r, input int idx);
        logic [31:0] word;
        logic [31:0] index;
        word  = {6'b010000, 1'b1, 5'(r), 5'd0, 3'b010, 5'd5, 7'h57};
        index = idx + (VLEN / (8 << model_sew)) * random_bits(2);
        issue(vector_pkg::VECTOR, vector_pkg::VMV_X_S, word, index, 32'd0);
        check_value("hold_o", 32'd0, 32'(hold));
        check_value("wr_en_scalar_o", 32'd1, 32'(wr_en_scalar));
        check_value("res_scalar_o", sign_extend(model_element(r, idx)), res_scalar);
    endtask

    function automatic vector_pkg::op_cat_e pick_category();
        case (random_bits(2) % 3)
            0:       return vector_pkg::OPIVV;
            1:       return vector_pkg::OPIVX;
            default: return vector_pkg::OPIVI;
        endcase
    endfunction

    task automatic run_op(input vector_pkg::vector_op_e op, input vector_pkg::op_cat_e cat,
                          input logic [2:0] sew, input logic [2:0] lmul,
                          input logic [31:0] avl);
        int          group;
        int          per_reg;
        int          g;
        int          vs1;
        int          vs2;
        int          vd;
        int          hold_cycles;
        logic [31:0] scalar;
        logic [4:0]  imm5;
        logic [4:0]  vs1_field;
        logic [31:0] operand_b;
        logic [31:0] b;
        configure(vector_pkg::VSETVLI, sew, lmul, 5'd3, avl);
        group   = 1 << lmul;
        per_reg = VLEN / (8 << sew);
        // Source and destination groups never overlap
        g       = random_bits(2);
        vs2     = (g % 4) * 8 + random_bits(3) % (9 - group);
        vs1     = ((g + 1) % 4) * 8 + random_bits(3) % (9 - group);
        vd      = ((g + 2) % 4) * 8 + random_bits(3) % (9 - group);
        scalar  = random_bits(32);
        imm5    = random_bits(5);
        if (op == vector_pkg::VSLL || op == vector_pkg::VSRL)
            operand_b = {27'd0, imm5};
        else
            operand_b = {{27{imm5[4]}}, imm5};
        if (cat == vector_pkg::OPIVX)
            operand_b = scalar;
        operand_b = operand_b & sew_mask();
        vs1_field = (cat == vector_pkg::OPIVI) ? imm5 : 5'(vs1);

        issue(vector_pkg::VECTOR, op, {6'd0, 1'b1, 5'(vs2), vs1_field, cat, 5'(vd), 7'h57},
              scalar, random_bits(32));
        hold_cycles = 0;
        while (hold && hold_cycles < 20) begin
            hold_cycles++;
            @(negedge clk);
        end
        if (hold_cycles != group + 1) begin
            errors++;
            $display("hold_o was high for %0d cycles where %0d were expected",
                     hold_cycles, group + 1);
        end

        for (int e = 0; e < group * per_reg; e++) begin
            if (e < model_vl) begin
                b = (cat == vector_pkg::OPIVV) ? model_element(vs1 + e / per_reg, e % per_reg)
                                               : operand_b;
                write_model_element(vd + e / per_reg, e % per_reg,
                                    model_op(op, model_element(vs2 + e / per_reg, e % per_reg), b));
            end
        end
        // Tail elements are read back too
        for (int e = 0; e < group * per_reg; e++)
            read_back(vd + e / per_reg, e % per_reg);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end
        else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int                       mark;
        logic [2:0]               sew;
        logic [2:0]               lmul;
        logic [4:0]               rs1;
        logic [31:0]              vlmax;
        vector_pkg::instr_class_e cls;
        vector_pkg::vector_op_e   op;
        reset_n           = 1'b0;
        instruction       = '0;
        instruction_class = vector_pkg::NONE;
        vector_operation  = vector_pkg::VADD;
        op1_scalar        = '0;
        op2_scalar        = '0;
        lfsr              = 16'd99;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        model_vl          = '0;
        model_sew         = '0;
        model_lmul        = '0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        mark = errors;
        @(negedge clk);
        check_value("vtype_o", 32'd0, 32'(vtype));
        check_value("hold_o", 32'd0, 32'(hold));
        check_value("wr_en_scalar_o", 32'd0, 32'(wr_en_scalar));
        read_back(random_bits(5), random_bits(2));
        finish_test("reset values", mark);

        mark = errors;
        for (int i = 0; i < CONFIG_RUNS; i++) begin
            sew  = random_bits(2) % 3;
            lmul = random_bits(2);
            rs1  = random_bits(5);
            if (random_bits(2) == 0)
                rs1 = 5'd0;
            case (random_bits(2) % 3)
                0:       cls = vector_pkg::VSETVLI;
                1:       cls = vector_pkg::VSETIVLI;
                default: cls = vector_pkg::VSETVL;
            endcase
            configure(cls, sew, lmul, rs1, random_bits(8));
        end
        finish_test("vsetvl family", mark);

        mark = errors;
        for (int i = 0; i < OP_RUNS; i++) begin
            op = vector_pkg::vector_op_e'(4'(random_bits(4) % 9));
            run_op(op, pick_category(), 3'(random_bits(2) % 3), 3'(random_bits(2)),
                   random_bits(7));
        end
        finish_test("random operations", mark);

        mark = errors;
        for (int i = 0; i < TAIL_RUNS; i++) begin
            sew   = random_bits(2) % 3;
            lmul  = random_bits(2);
            vlmax = (VLEN / (8 << sew)) << lmul;
            op    = vector_pkg::vector_op_e'(4'(random_bits(4) % 9));
            run_op(op, pick_category(), sew, lmul, random_bits(8) % vlmax);
        end
        finish_test("tail undisturbed", mark);

        mark = errors;
        for (int i = 0; i < SHIFT_RUNS; i++) begin
            case (i % 4)
                0:       op = vector_pkg::VSLL;
                1:       op = vector_pkg::VSRL;
                2:       op = vector_pkg::VADD;
                default: op = vector_pkg::VSUB;
            endcase
            run_op(op, random_bits(1) ? vector_pkg::OPIVI : vector_pkg::OPIVX,
                   3'(random_bits(2) % 3), 3'(random_bits(2)), 32'hFF);
        end
        finish_test("shifts and immediates", mark);

        errors = errors + UUT.property_checks.assert_failures;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors,
                 UUT.property_checks.assert_failures);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/vector_pkg.sv
source/vector_csrs.sv
source/vector_regbank.sv
source/vector_alu.sv
source/vector_unit.sv
tests/vector_unit_properties.sv
tests/vector_unit_tb.sv

//--- Bender.yml
package:
  name: vector_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/vector_pkg.sv
      - source/vector_csrs.sv
      - source/vector_regbank.sv
      - source/vector_alu.sv
      - source/vector_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/vector_unit_properties.sv
      - tests/vector_unit_tb.sv
